// File: hw/riscvPkg.sv
package riscvPkg;

    localparam int xlen = 32; // RV32I word width

    typedef logic [xlen-1:0] wordT;   // data or address
    typedef logic [31:0]     instrT;  // raw instruction
    typedef logic [6:0]      opcodeT;
    typedef logic [2:0]      funct3T;
    typedef logic [4:0]      regAddrT;
    typedef logic [2:0]      aluOpT;     // class from main decoder
    typedef logic [3:0]      aluCtrlT;   // alu operation select
    typedef logic [2:0]      immSrcT;    // immediate format
    typedef logic [1:0]      resultSrcT; // writeback source
    typedef logic [1:0]      pcSrcT;     // next pc select

    // base opcodes
    localparam opcodeT opRType  = 7'b0110011;
    localparam opcodeT opIType  = 7'b0010011;
    localparam opcodeT opLoad   = 7'b0000011;
    localparam opcodeT opStore  = 7'b0100011;
    localparam opcodeT opBranch = 7'b1100011;
    localparam opcodeT opJal    = 7'b1101111;
    localparam opcodeT opJalr   = 7'b1100111;
    localparam opcodeT opLui    = 7'b0110111;
    localparam opcodeT opAuipc  = 7'b0010111;

    // alu op classes, jal and jalr share the jump class
    localparam aluOpT aluOpR      = 3'b000;
    localparam aluOpT aluOpI      = 3'b001;
    localparam aluOpT aluOpLoad   = 3'b010;
    localparam aluOpT aluOpStore  = 3'b011;
    localparam aluOpT aluOpBranch = 3'b100;
    localparam aluOpT aluOpJump   = 3'b101;
    localparam aluOpT aluOpLui    = 3'b110;
    localparam aluOpT aluOpAuipc  = 3'b111;

    // alu control codes
    localparam aluCtrlT aluAdd   = 4'd0;
    localparam aluCtrlT aluSub   = 4'd1;
    localparam aluCtrlT aluAnd   = 4'd2;
    localparam aluCtrlT aluOr    = 4'd3;
    localparam aluCtrlT aluXor   = 4'd4;
    localparam aluCtrlT aluSlt   = 4'd5;
    localparam aluCtrlT aluSltu  = 4'd6;
    localparam aluCtrlT aluSll   = 4'd7;
    localparam aluCtrlT aluSrl   = 4'd8;
    localparam aluCtrlT aluSra   = 4'd9;
    localparam aluCtrlT aluPassB = 4'd10;

    // immediate formats
    localparam immSrcT immI = 3'b000;
    localparam immSrcT immS = 3'b001;
    localparam immSrcT immB = 3'b010;
    localparam immSrcT immU = 3'b011;
    localparam immSrcT immJ = 3'b100;

    // branch funct3
    localparam funct3T f3Beq  = 3'b000;
    localparam funct3T f3Bne  = 3'b001;
    localparam funct3T f3Blt  = 3'b100;
    localparam funct3T f3Bge  = 3'b101;
    localparam funct3T f3Bltu = 3'b110;
    localparam funct3T f3Bgeu = 3'b111;

endpackage

// File: hw/control.sv
`timescale 1ns/1ps

module control (
    input  riscvPkg::opcodeT    opcode,     // instr 6:0 in decode
    input  logic                flagE,      // branch taken, from execute
    output riscvPkg::pcSrcT     pcSrcD,
    output riscvPkg::resultSrcT resultSrcD,
    output logic                memWriteD,
    output logic                aluSrcD,
    output riscvPkg::immSrcT    immSrcD,
    output logic                regWriteD,
    output riscvPkg::aluOpT     aluOpD,     // to aluDecode
    output logic                jalrD
);

    always_comb begin
        // defaults match an unknown opcode, nothing written
        aluOpD     = riscvPkg::aluOpR;
        resultSrcD = 2'b00;           // alu result
        memWriteD  = 1'b0;
        aluSrcD    = 1'b0;            // rs2
        immSrcD    = riscvPkg::immI;
        regWriteD  = 1'b0;
        jalrD      = 1'b0;
        pcSrcD     = 2'b00;           // pc + 4

        case (opcode)
            riscvPkg::opRType: begin
                aluOpD    = riscvPkg::aluOpR;
                regWriteD = 1'b1;
            end
            riscvPkg::opIType: begin
                aluOpD    = riscvPkg::aluOpI;
                aluSrcD   = 1'b1;
                immSrcD   = riscvPkg::immI;
                regWriteD = 1'b1;
            end
            riscvPkg::opLoad: begin
                aluOpD     = riscvPkg::aluOpLoad;
                resultSrcD = 2'b01;   // memory read data
                aluSrcD    = 1'b1;
                immSrcD    = riscvPkg::immI;
                regWriteD  = 1'b1;
            end
            riscvPkg::opStore: begin
                aluOpD    = riscvPkg::aluOpStore;
                memWriteD = 1'b1;
                aluSrcD   = 1'b1;
                immSrcD   = riscvPkg::immS;
            end
            riscvPkg::opBranch: begin
                aluOpD  = riscvPkg::aluOpBranch;
                immSrcD = riscvPkg::immB;
                pcSrcD  = flagE ? 2'b01 : 2'b00; // flag belongs to execute instr
            end
            riscvPkg::opJal: begin
                aluOpD     = riscvPkg::aluOpJump;
                resultSrcD = 2'b10;   // link value
                aluSrcD    = 1'b1;
                immSrcD    = riscvPkg::immJ;
                regWriteD  = 1'b1;
                pcSrcD     = 2'b01;   // pc + imm
            end
            riscvPkg::opJalr: begin
                aluOpD     = riscvPkg::aluOpJump; // jalr flag splits it later
                resultSrcD = 2'b10;
                aluSrcD    = 1'b1;
                immSrcD    = riscvPkg::immI;      // 12 bit offset on rs1
                regWriteD  = 1'b1;
                jalrD      = 1'b1;
                pcSrcD     = 2'b11;   // rs1 + imm
            end
            riscvPkg::opLui: begin
                aluOpD    = riscvPkg::aluOpLui;
                aluSrcD   = 1'b1;
                immSrcD   = riscvPkg::immU;
                regWriteD = 1'b1;     // result src stays at alu
            end
            riscvPkg::opAuipc: begin
                aluOpD     = riscvPkg::aluOpAuipc;
                resultSrcD = 2'b11;
                aluSrcD    = 1'b1;
                immSrcD    = riscvPkg::immU;
                regWriteD  = 1'b1;
            end
            default: begin
                aluOpD = riscvPkg::aluOpR; // illegal, treated as no-op
            end
        endcase
    end

endmodule

// File: hw/aluDecode.sv
`timescale 1ns/1ps

module aluDecode (
    input  riscvPkg::aluOpT   aluOp,
    input  riscvPkg::funct3T  funct3,
    input  logic              funct7b5, // instr bit 30
    output riscvPkg::aluCtrlT aluCtrl
);

    riscvPkg::aluCtrlT opCtrl; // funct3 based choice for r and i class

    // shared funct3 table, sub only allowed for r class
    always_comb begin
        case (funct3)
            3'b000: begin
                if (aluOp == riscvPkg::aluOpR && funct7b5) begin
                    opCtrl = riscvPkg::aluSub;
                end else begin
                    opCtrl = riscvPkg::aluAdd; // addi ignores bit 30
                end
            end
            3'b001: opCtrl = riscvPkg::aluSll;
            3'b010: opCtrl = riscvPkg::aluSlt;
            3'b011: opCtrl = riscvPkg::aluSltu;
            3'b100: opCtrl = riscvPkg::aluXor;
            3'b101: opCtrl = funct7b5 ? riscvPkg::aluSra : riscvPkg::aluSrl;
            3'b110: opCtrl = riscvPkg::aluOr;
            default: opCtrl = riscvPkg::aluAnd; // 111
        endcase
    end

    always_comb begin
        case (aluOp)
            riscvPkg::aluOpR,
            riscvPkg::aluOpI:   aluCtrl = opCtrl;
            riscvPkg::aluOpLui: aluCtrl = riscvPkg::aluPassB; // imm straight through
            default:            aluCtrl = riscvPkg::aluAdd;   // address or target
        endcase
    end

endmodule

// File: hw/immExtend.sv
`timescale 1ns/1ps

module immExtend (
    input  riscvPkg::instrT  instr,
    input  riscvPkg::immSrcT immSrc,
    output riscvPkg::wordT   immExt
);

    always_comb begin
        case (immSrc)
            riscvPkg::immS: immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            riscvPkg::immB: immExt = {{20{instr[31]}}, instr[7], instr[30:25],
                                      instr[11:8], 1'b0};           // 13 bit, even
            riscvPkg::immU: immExt = {instr[31:12], 12'b0};         // upper 20
            riscvPkg::immJ: immExt = {{12{instr[31]}}, instr[19:12], instr[20],
                                      instr[30:21], 1'b0};          // 21 bit, even
            default:        immExt = {{20{instr[31]}}, instr[31:20]}; // i format
        endcase
    end

endmodule

// File: hw/decodeExecuteReg.sv
`timescale 1ns/1ps

module decodeExecuteReg (
    input  logic                clk,
    input  logic                rst,
    input  logic                flush,      // insert bubble
    input  logic                regWriteD,
    input  logic                memWriteD,
    input  riscvPkg::resultSrcT resultSrcD,
    input  logic                aluSrcD,
    input  logic                jalrD,
    input  riscvPkg::aluOpT     aluOpD,
    input  riscvPkg::aluCtrlT   aluCtrlD,
    input  riscvPkg::funct3T    funct3D,
    input  riscvPkg::regAddrT   rdD,
    input  riscvPkg::wordT      pcD,
    input  riscvPkg::wordT      rs1DataD,
    input  riscvPkg::wordT      rs2DataD,
    input  riscvPkg::wordT      immExtD,
    output logic                regWriteE,
    output logic                memWriteE,
    output riscvPkg::resultSrcT resultSrcE,
    output logic                aluSrcE,
    output logic                jalrE,
    output riscvPkg::aluOpT     aluOpE,
    output riscvPkg::aluCtrlT   aluCtrlE,
    output riscvPkg::funct3T    funct3E,
    output riscvPkg::regAddrT   rdE,
    output riscvPkg::wordT      pcE,
    output riscvPkg::wordT      rs1DataE,
    output riscvPkg::wordT      rs2DataE,
    output riscvPkg::wordT      immExtE
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin // flush wins over load
            regWriteE  <= 1'b0;
            memWriteE  <= 1'b0;
            resultSrcE <= '0;
            aluSrcE    <= 1'b0;
            jalrE      <= 1'b0;
            aluOpE     <= '0;   // r class, never flags a branch
            aluCtrlE   <= '0;
            funct3E    <= '0;
            rdE        <= '0;
            pcE        <= '0;
            rs1DataE   <= '0;
            rs2DataE   <= '0;
            immExtE    <= '0;
        end else begin
            regWriteE  <= regWriteD;
            memWriteE  <= memWriteD;
            resultSrcE <= resultSrcD;
            aluSrcE    <= aluSrcD;
            jalrE      <= jalrD;
            aluOpE     <= aluOpD;
            aluCtrlE   <= aluCtrlD;
            funct3E    <= funct3D;
            rdE        <= rdD;
            pcE        <= pcD;
            rs1DataE   <= rs1DataD;
            rs2DataE   <= rs2DataD;
            immExtE    <= immExtD;
        end
    end

endmodule

// File: hw/alu.sv
`timescale 1ns/1ps

module alu (
    input  riscvPkg::wordT    srcA,
    input  riscvPkg::wordT    srcB,
    input  riscvPkg::aluCtrlT aluCtrl,
    output riscvPkg::wordT    result
);

    logic [4:0] shamt; // only low 5 bits shift
    logic       ltS;   // signed less than
    logic       ltU;   // unsigned less than

    assign shamt = srcB[4:0];
    assign ltS   = $signed(srcA) < $signed(srcB);
    assign ltU   = srcA < srcB;

    always_comb begin
        case (aluCtrl)
            riscvPkg::aluAdd:   result = srcA + srcB;
            riscvPkg::aluSub:   result = srcA - srcB;
            riscvPkg::aluAnd:   result = srcA & srcB;
            riscvPkg::aluOr:    result = srcA | srcB;
            riscvPkg::aluXor:   result = srcA ^ srcB;
            riscvPkg::aluSlt:   result = {31'b0, ltS}; // 0 or 1
            riscvPkg::aluSltu:  result = {31'b0, ltU};
            riscvPkg::aluSll:   result = srcA << shamt;
            riscvPkg::aluSrl:   result = srcA >> shamt;
            riscvPkg::aluSra:   result = riscvPkg::wordT'($signed(srcA) >>> shamt);
            riscvPkg::aluPassB: result = srcB;          // lui
            default:            result = '0;
        endcase
    end

endmodule

// File: hw/executeStage.sv
`timescale 1ns/1ps

module executeStage (
    input  riscvPkg::aluOpT   aluOp,
    input  riscvPkg::aluCtrlT aluCtrl,
    input  logic              aluSrc,   // 1 picks immediate
    input  logic              jalr,
    input  riscvPkg::funct3T  funct3,
    input  riscvPkg::wordT    pc,
    input  riscvPkg::wordT    rs1Data,
    input  riscvPkg::wordT    rs2Data,
    input  riscvPkg::wordT    immExt,
    output riscvPkg::wordT    aluResult,
    output logic              flag      // branch condition holds
);

    riscvPkg::wordT srcA;
    riscvPkg::wordT srcB;
    logic           usePc; // pc relative classes

    assign usePc = (aluOp == riscvPkg::aluOpBranch) || (aluOp == riscvPkg::aluOpAuipc)
                || (aluOp == riscvPkg::aluOpJump && !jalr);
    assign srcA  = usePc ? pc : rs1Data;
    assign srcB  = aluSrc ? immExt : rs2Data;

    alu aluInst (
        .srcA    (srcA),
        .srcB    (srcB),
        .aluCtrl (aluCtrl),
        .result  (aluResult)
    );

    // compare registers directly, alu is busy with the target
    always_comb begin
        flag = 1'b0;
        if (aluOp == riscvPkg::aluOpBranch) begin
            case (funct3)
                riscvPkg::f3Beq:  flag = rs1Data == rs2Data;
                riscvPkg::f3Bne:  flag = rs1Data != rs2Data;
                riscvPkg::f3Blt:  flag = $signed(rs1Data) < $signed(rs2Data);
                riscvPkg::f3Bge:  flag = $signed(rs1Data) >= $signed(rs2Data);
                riscvPkg::f3Bltu: flag = rs1Data < rs2Data;
                riscvPkg::f3Bgeu: flag = rs1Data >= rs2Data;
                default:          flag = 1'b0; // 010, 011 undefined
            endcase
        end
    end

endmodule

// File: hw/controlPath.sv
`timescale 1ns/1ps

module controlPath (
    input  logic                clk,
    input  logic                rst,
    input  logic                flushE,
    input  riscvPkg::instrT     instrD,
    input  riscvPkg::wordT      pcD,
    input  riscvPkg::wordT      rs1DataD,
    input  riscvPkg::wordT      rs2DataD,
    output riscvPkg::pcSrcT     pcSrcD,     // same cycle as instrD
    output riscvPkg::wordT      aluResultE,
    output riscvPkg::wordT      writeDataE, // store data
    output riscvPkg::regAddrT   rdE,
    output logic                regWriteE,
    output logic                memWriteE,
    output riscvPkg::resultSrcT resultSrcE,
    output logic                flagE
);

    riscvPkg::opcodeT    opcodeD;
    riscvPkg::funct3T    funct3D;
    riscvPkg::regAddrT   rdD;
    logic                funct7b5D;
    riscvPkg::resultSrcT resultSrcD;
    logic                memWriteD, aluSrcD, regWriteD, jalrD;
    riscvPkg::immSrcT    immSrcD;
    riscvPkg::aluOpT     aluOpD;
    riscvPkg::aluCtrlT   aluCtrlD;
    riscvPkg::wordT      immExtD;
    logic                aluSrcE, jalrE;
    riscvPkg::aluOpT     aluOpE;
    riscvPkg::aluCtrlT   aluCtrlE;
    riscvPkg::funct3T    funct3E;
    riscvPkg::wordT      pcE, rs1DataE, immExtE;

    // instruction fields
    assign opcodeD   = instrD[6:0];
    assign rdD       = instrD[11:7];
    assign funct3D   = instrD[14:12];
    assign funct7b5D = instrD[30];

    control controlInst (
        .opcode     (opcodeD),
        .flagE      (flagE),      // loops back from execute
        .pcSrcD     (pcSrcD),
        .resultSrcD (resultSrcD),
        .memWriteD  (memWriteD),
        .aluSrcD    (aluSrcD),
        .immSrcD    (immSrcD),
        .regWriteD  (regWriteD),
        .aluOpD     (aluOpD),
        .jalrD      (jalrD)
    );

    aluDecode aluDecodeInst (
        .aluOp    (aluOpD),
        .funct3   (funct3D),
        .funct7b5 (funct7b5D),
        .aluCtrl  (aluCtrlD)
    );

    immExtend immExtendInst (
        .instr  (instrD),
        .immSrc (immSrcD),
        .immExt (immExtD)
    );

    decodeExecuteReg deRegInst (
        .clk        (clk),
        .rst        (rst),
        .flush      (flushE),
        .regWriteD  (regWriteD),
        .memWriteD  (memWriteD),
        .resultSrcD (resultSrcD),
        .aluSrcD    (aluSrcD),
        .jalrD      (jalrD),
        .aluOpD     (aluOpD),
        .aluCtrlD   (aluCtrlD),
        .funct3D    (funct3D),
        .rdD        (rdD),
        .pcD        (pcD),
        .rs1DataD   (rs1DataD),
        .rs2DataD   (rs2DataD),
        .immExtD    (immExtD),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .resultSrcE (resultSrcE),
        .aluSrcE    (aluSrcE),
        .jalrE      (jalrE),
        .aluOpE     (aluOpE),
        .aluCtrlE   (aluCtrlE),
        .funct3E    (funct3E),
        .rdE        (rdE),
        .pcE        (pcE),
        .rs1DataE   (rs1DataE),
        .rs2DataE   (writeDataE), // rs2 doubles as store data
        .immExtE    (immExtE)
    );

    executeStage executeInst (
        .aluOp     (aluOpE),
        .aluCtrl   (aluCtrlE),
        .aluSrc    (aluSrcE),
        .jalr      (jalrE),
        .funct3    (funct3E),
        .pc        (pcE),
        .rs1Data   (rs1DataE),
        .rs2Data   (writeDataE),
        .immExt    (immExtE),
        .aluResult (aluResultE),
        .flag      (flagE)
    );

endmodule

// File: verif/controlPathTb.sv
`timescale 1ns/1ps

module controlPathTb;

    logic                clk;
    logic                rst;
    logic                flushE;
    riscvPkg::instrT     instrD;
    riscvPkg::wordT      pcD;
    riscvPkg::wordT      rs1DataD;
    riscvPkg::wordT      rs2DataD;
    riscvPkg::pcSrcT     pcSrcD;
    riscvPkg::wordT      aluResultE;
    riscvPkg::wordT      writeDataE;
    riscvPkg::regAddrT   rdE;
    logic                regWriteE;
    logic                memWriteE;
    riscvPkg::resultSrcT resultSrcE;
    logic                flagE;

    // one entry per cycle from trace lines and random tail
    riscvPkg::instrT     instrQ[$];
    riscvPkg::wordT      pcQ[$];
    riscvPkg::wordT      rs1Q[$];
    riscvPkg::wordT      rs2Q[$];
    logic                flushQ[$];
    riscvPkg::pcSrcT     pcSrcQ[$];
    riscvPkg::wordT      aluQ[$];
    riscvPkg::wordT      wdQ[$];
    riscvPkg::regAddrT   rdQ[$];
    logic                rwQ[$];
    logic                mwQ[$];
    riscvPkg::resultSrcT rsQ[$];
    logic                flagQ[$];

    int traceLen   = 0; // lines read from file
    int errorCount = 0;
    int curErrors  = 0; // errors of the test in flight
    int failedTests = 0;
    int testCount  = 0;
    bit loadOk     = 0;

    controlPath dut (
        .clk        (clk),
        .rst        (rst),
        .flushE     (flushE),
        .instrD     (instrD),
        .pcD        (pcD),
        .rs1DataD   (rs1DataD),
        .rs2DataD   (rs2DataD),
        .pcSrcD     (pcSrcD),
        .aluResultE (aluResultE),
        .writeDataE (writeDataE),
        .rdE        (rdE),
        .regWriteE  (regWriteE),
        .memWriteE  (memWriteE),
        .resultSrcE (resultSrcE),
        .flagE      (flagE)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk; // 40 ns period

    task automatic checkWord(input string what, input riscvPkg::wordT got,
                             input riscvPkg::wordT exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %h, expected %h", $time, what, got, exp);
            errorCount++;
            curErrors++;
        end
    endtask

    task automatic checkPcSrc(input riscvPkg::pcSrcT got, input riscvPkg::pcSrcT exp);
        if (got !== exp) begin
            $display("ERR %0t: pcSrcD is %b, expected %b", $time, got, exp);
            errorCount++;
            curErrors++;
        end
    endtask

    task automatic checkResultSrc(input riscvPkg::resultSrcT got,
                                  input riscvPkg::resultSrcT exp);
        if (got !== exp) begin
            $display("ERR %0t: resultSrcE is %b, expected %b", $time, got, exp);
            errorCount++;
            curErrors++;
        end
    endtask

    task automatic checkReg(input riscvPkg::regAddrT got, input riscvPkg::regAddrT exp);
        if (got !== exp) begin
            $display("ERR %0t: rdE is %0d, expected %0d", $time, got, exp);
            errorCount++;
            curErrors++;
        end
    endtask

    task automatic checkBit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            errorCount++;
            curErrors++;
        end
    endtask

    // parse the trace and skip comment lines
    task automatic readTrace();
        int                  fd;
        int                  n;
        string               line;
        riscvPkg::instrT     ins;
        riscvPkg::wordT      pc, a, b, res, wd;
        logic                fl, rw, mw, fg;
        riscvPkg::pcSrcT     ps;
        riscvPkg::regAddrT   rd;
        riscvPkg::resultSrcT rs;
        fd = $fopen("verif/controlPathTrace.txt", "r");
        if (fd != 0) begin
            loadOk = 1;
            while ($fgets(line, fd) != 0) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                                ins, pc, a, b, fl, ps, res, wd, rd, rw, mw, rs, fg);
                    if (n != 13) begin
                        $display("malformed trace line: %s", line);
                        loadOk = 0;
                    end
                    instrQ.push_back(ins);
                    pcQ.push_back(pc);
                    rs1Q.push_back(a);
                    rs2Q.push_back(b);
                    flushQ.push_back(fl);
                    pcSrcQ.push_back(ps);
                    aluQ.push_back(res);
                    wdQ.push_back(wd);
                    rdQ.push_back(rd);
                    rwQ.push_back(rw);
                    mwQ.push_back(mw);
                    rsQ.push_back(rs);
                    flagQ.push_back(fg);
                end
            end
            $fclose(fd);
            traceLen = instrQ.size();
        end
    endtask

    // add x3, x1, x2 with random operands and random flushes
    task automatic addTail(input int count);
        riscvPkg::wordT a;
        riscvPkg::wordT b;
        logic           fl;
        for (int k = 0; k < count; k++) begin
            a  = $urandom;
            b  = $urandom;
            fl = (($urandom % 3) == 0);
            instrQ.push_back(32'h002081B3);
            pcQ.push_back(32'h00000200 + 32'(4 * k));
            rs1Q.push_back(a);
            rs2Q.push_back(b);
            flushQ.push_back(fl);
            pcSrcQ.push_back(2'b00);             // not a branch or jump
            aluQ.push_back(fl ? 32'h0 : a + b);  // bubble or sum
            wdQ.push_back(fl ? 32'h0 : b);
            rdQ.push_back(fl ? 5'd0 : 5'd3);
            rwQ.push_back(!fl);
            mwQ.push_back(1'b0);
            rsQ.push_back(2'b00);
            flagQ.push_back(1'b0);
        end
    endtask

    // E outputs of entry i sampled at mid cycle
    task automatic checkExecute(input int i);
        if (instrQ[i][6:0] != riscvPkg::opBranch || flushQ[i]) begin
            checkWord("aluResultE", aluResultE, aluQ[i]); // branch target unchecked
        end
        checkWord("writeDataE", writeDataE, wdQ[i]);
        checkReg(rdE, rdQ[i]);
        checkBit("regWriteE", regWriteE, rwQ[i]);
        checkBit("memWriteE", memWriteE, mwQ[i]);
        checkResultSrc(resultSrcE, rsQ[i]);
        checkBit("flagE", flagE, flagQ[i]);
    endtask

    task automatic finishTest(input string name);
        testCount++;
        if (curErrors == 0) begin
            $display("test %s: pass", name);
        end else begin
            $display("test %s: %0d mismatches", name, curErrors);
            failedTests++;
        end
        curErrors = 0;
    endtask

    initial begin
        rst      = 1'b1;
        flushE   = 1'b0;
        instrD   = 32'h002081B3;  // add x3 would write if loaded
        pcD      = '0;
        rs1DataD = 32'h00000005;
        rs2DataD = 32'h00000005;  // equal operands make a beq taken
        void'($urandom(82));
        readTrace();
        if (!loadOk) begin
            $display("trace file missing or unreadable, nothing was run");
            $display("Simulation failed");
            $finish;
        end else begin
            addTail(5);
            @(posedge clk);             // first reset edge
            @(negedge clk);
            checkBit("regWriteE", regWriteE, 1'b0); // add held off by reset
            instrD = 32'h00208863;      // beq x1 x2 taken if it got through
            @(posedge clk);             // second reset edge
            @(negedge clk);
            rst = 1'b0;
            checkBit("regWriteE", regWriteE, 1'b0); // bubble after reset
            checkBit("memWriteE", memWriteE, 1'b0);
            checkBit("flagE", flagE, 1'b0);
            checkWord("writeDataE", writeDataE, 32'h0);
            checkReg(rdE, 5'd0);
            checkPcSrc(pcSrcD, 2'b00);  // branch in decode sees no flag
            finishTest("reset");
            for (int i = 0; i < instrQ.size(); i++) begin
                if (i > 0) begin
                    checkExecute(i - 1);
                    finishTest($sformatf("%0d instr %h", i - 1, instrQ[i - 1]));
                end
                instrD   = instrQ[i];
                pcD      = pcQ[i];
                rs1DataD = rs1Q[i];
                rs2DataD = rs2Q[i];
                flushE   = flushQ[i];
                #19;                    // just before the rising edge
                checkPcSrc(pcSrcD, pcSrcQ[i]);
                @(negedge clk);
            end
            checkExecute(instrQ.size() - 1);
            finishTest($sformatf("%0d instr %h", instrQ.size() - 1,
                                 instrQ[instrQ.size() - 1]));
            $display("%0d tests, %0d passed, %0d failed, %0d mismatches", testCount,
                     testCount - failedTests, failedTests, errorCount);
            if (errorCount == 0) begin
                $display("Simulation completed successfully");
            end else begin
                $display("Simulation failed");
            end
            $finish;
        end
    end

    // watchdog sized from the trace length
    initial begin
        wait (traceLen > 0);
        #((traceLen + 10) * 40);
        $display("run timed out after %0d trace lines worth of cycles", traceLen + 10);
        $display("Simulation failed");
        $finish;
    end

endmodule

// File: verif/controlPathTrace.txt
# instrD pcD rs1DataD rs2DataD flushE pcSrcD | next cycle: aluResultE writeDataE rdE
# regWriteE memWriteE resultSrcE flagE (branch aluResultE is not checked, given as 0)
002081B3 00000100 00000005 00000007 0 0 0000000C 00000007 03 1 0 0 0
40208233 00000104 00000005 00000007 0 0 FFFFFFFE 00000007 04 1 0 0 0
0020F2B3 00000108 F0F0F0F0 0FF00FF0 0 0 00F000F0 0FF00FF0 05 1 0 0 0
0020E333 0000010C F0F0F0F0 0FF00FF0 0 0 FFF0FFF0 0FF00FF0 06 1 0 0 0
0020C3B3 00000110 F0F0F0F0 0FF00FF0 0 0 FF00FF00 0FF00FF0 07 1 0 0 0
0020A433 00000114 FFFFFFFF 00000001 0 0 00000001 00000001 08 1 0 0 0
0020B4B3 00000118 FFFFFFFF 00000001 0 0 00000000 00000001 09 1 0 0 0
00209533 0000011C 00000003 00000024 0 0 00000030 00000024 0A 1 0 0 0
0020D1B3 00000120 80000000 00000004 0 0 08000000 00000004 03 1 0 0 0
4020D233 00000124 80000000 00000004 0 0 F8000000 00000004 04 1 0 0 0
FFF08293 00000128 00000010 00000000 0 0 0000000F 00000000 05 1 0 0 0
40008313 0000012C 00000010 00000000 0 0 00000410 00000000 06 1 0 0 0
4030D393 00000130 FFFFFF00 00000000 0 0 FFFFFFE0 00000000 07 1 0 0 0
FFF0B413 00000134 00000005 00000000 0 0 00000001 00000000 08 1 0 0 0
0FF0C493 00000138 F0F0F0F0 00000000 0 0 F0F0F00F 00000000 09 1 0 0 0
FFC0A503 0000013C 00001000 00000000 0 0 00000FFC 00000000 0A 1 0 1 0
0020A423 00000140 00001000 DEADBEEF 0 0 00001008 DEADBEEF 08 0 1 0 0
FE20AE23 00000144 00001000 12345678 0 0 00000FFC 12345678 1C 0 1 0 0
123451B7 00000148 00000000 00000000 0 0 12345000 00000000 03 1 0 0 0
00001217 0000014C 00000000 00000000 0 0 0000114C 00000000 04 1 0 3 0
008000EF 00000150 00000000 00000000 0 1 00000158 00000000 01 1 0 2 0
004280E7 00000154 00003000 00000000 0 3 00003004 00000000 01 1 0 2 0
00208863 00000158 00000005 00000005 0 0 00000000 00000005 10 0 0 0 1
00209863 0000015C 00000005 00000005 0 1 00000000 00000005 10 0 0 0 0
0020C863 00000160 FFFFFFFF 00000001 0 0 00000000 00000001 10 0 0 0 1
0020D863 00000164 FFFFFFFF 00000001 0 1 00000000 00000001 10 0 0 0 0
0020E863 00000168 FFFFFFFF 00000001 0 0 00000000 00000001 10 0 0 0 0
0020F863 0000016C FFFFFFFF 00000001 0 0 00000000 00000001 10 0 0 0 1
00209863 00000170 00000005 00000006 0 1 00000000 00000006 10 0 0 0 1
00208863 00000174 00000005 00000005 1 1 00000000 00000000 00 0 0 0 0
00208863 00000178 00000005 00000005 0 0 00000000 00000005 10 0 0 0 1
00208863 0000017C 00000005 00000006 0 1 00000000 00000006 10 0 0 0 0
002081B3 00000180 00000001 00000002 0 0 00000003 00000002 03 1 0 0 0

// File: filelist.f
hw/riscvPkg.sv
hw/control.sv
hw/aluDecode.sv
hw/immExtend.sv
hw/decodeExecuteReg.sv
hw/alu.sv
hw/executeStage.sv
hw/controlPath.sv
verif/controlPathTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= controlPathTb
BUILD_DIR ?= build
LOG       ?= sim.log

SRCS := $(shell grep -v '^+' filelist.f)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): filelist.f $(SRCS)
	$(VERILATOR) --binary --timing -f filelist.f --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

run: $(BIN) verif/controlPathTrace.txt
	./$(BIN) 2>&1 | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
